// ==== hw/fpu_config.svh ====
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// ------------------------------
// lane array
// ------------------------------

// identical compare and sign-inject lanes fed round-robin
`define FPU_NUM_LANES 4

// result queue entries in every lane
`define FPU_LANE_DEPTH 2

// ------------------------------
// flow control
// ------------------------------

// producer credits after reset, one per queue entry over all lanes
`define FPU_IN_CREDITS 8

// credits the collector holds toward the consumer after reset
`define FPU_OUT_CREDITS 4

// width of a credit counter
`define FPU_CRED_W 4

// destination register index width
`define FPU_REG_IDX_W 5

`endif

// ==== hw/fpu_pkg.sv ====
`include "fpu_config.svh"

package fpu_pkg;

    // ------------------------------
    // operand format
    // ------------------------------

    // single-precision word
    typedef struct packed {
        logic       sign;
        logic [7:0] exponent;
        logic [22:0] fraction;
    } float32_t;

    // ------------------------------
    // operations
    // ------------------------------

    // the first three write the integer file, the rest the float file
    typedef enum logic [2:0] {
        FEQ    = 3'd0,
        FLT    = 3'd1,
        FLE    = 3'd2,
        FMIN   = 3'd3,
        FMAX   = 3'd4,
        FSGNJ  = 3'd5,
        FSGNJN = 3'd6,
        FSGNJX = 3'd7
    } fpu_op_t;

    // one request as the lanes see it
    typedef struct packed {
        float32_t                  a;
        float32_t                  b;
        fpu_op_t                   op;
        logic [`FPU_REG_IDX_W-1:0] rd;
    } fpu_req_t;

    // one result with its flags and destination
    typedef struct packed {
        float32_t                  data;
        logic                      invalid;
        logic                      is_float;
        logic [`FPU_REG_IDX_W-1:0] rd;
    } fpu_resp_t;

endpackage : fpu_pkg

// ==== hw/fpu_credit_fifo.sv ====
module fpu_credit_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 2
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     push_i,
    input  payload_t data_i,
    input  logic     pop_i,
    output logic     valid_o,
    output payload_t data_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // payload storage, written at the write pointer on every push
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr] <= data_i;
        end
    end

    // pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push_i) - CNT_W'(pop_i);
        end
    end

    // the head is read straight from storage
    assign valid_o = (count != '0);
    assign data_o  = mem[rd_ptr];

endmodule : fpu_credit_fifo

// ==== hw/fpu_dispatch.sv ====
`include "fpu_config.svh"

module fpu_dispatch (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      req_valid_i,
    output logic [`FPU_NUM_LANES-1:0] lane_valid_o
);

    localparam int NUM_LANES = `FPU_NUM_LANES;
    localparam int PTR_W     = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [PTR_W-1:0] issue_ptr;

    // every valid request is accepted, credits already bound the traffic
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            issue_ptr <= '0;
        end else if (req_valid_i) begin
            issue_ptr <= (issue_ptr == PTR_W'(NUM_LANES - 1)) ? '0 : issue_ptr + 1'b1;
        end
    end

    // one-hot select of the lane that takes this request
    always_comb begin
        lane_valid_o            = '0;
        lane_valid_o[issue_ptr] = req_valid_i;
    end

endmodule : fpu_dispatch

// ==== hw/fpu_lane.sv ====
`include "fpu_config.svh"

module fpu_lane import fpu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  logic      valid_i,
    input  fpu_req_t  req_i,
    input  logic      pop_i,
    output logic      head_valid_o,
    output fpu_resp_t head_o
);

    // ------------------------------
    // compute stage register
    // ------------------------------

    logic     valid_q;
    fpu_req_t req_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            req_q <= req_i;
        end
    end

    // ------------------------------
    // operand classification
    // ------------------------------

    float32_t a;
    float32_t b;
    logic     a_nan;
    logic     b_nan;
    logic     a_snan;
    logic     b_snan;
    logic     both_zero;
    logic     eq;
    logic     lt_raw;

    assign a = req_q.a;
    assign b = req_q.b;

    assign a_nan  = (a.exponent == 8'hff) && (a.fraction != '0);
    assign b_nan  = (b.exponent == 8'hff) && (b.fraction != '0);
    assign a_snan = a_nan && !a.fraction[22];
    assign b_snan = b_nan && !b.fraction[22];

    assign both_zero = (a[30:0] == '0) && (b[30:0] == '0);
    assign eq        = !a_nan && !b_nan && ((a == b) || both_zero);

    // total order on magnitude and sign, so -0 sits below +0
    always_comb begin
        if (a.sign != b.sign) begin
            lt_raw = a.sign;
        end else if (a.sign) begin
            lt_raw = a[30:0] > b[30:0];
        end else begin
            lt_raw = a[30:0] < b[30:0];
        end
    end

    // ------------------------------
    // result selection
    // ------------------------------

    fpu_resp_t resp;

    always_comb begin
        resp          = '0;
        resp.rd       = req_q.rd;
        resp.is_float = 1'b1;
        case (req_q.op)
            FEQ: begin
                resp.data     = {31'b0, eq};
                resp.invalid  = a_snan || b_snan;
                resp.is_float = 1'b0;
            end
            FLT: begin
                resp.data     = {31'b0, !a_nan && !b_nan && lt_raw && !both_zero};
                resp.invalid  = a_nan || b_nan;
                resp.is_float = 1'b0;
            end
            FLE: begin
                resp.data     = {31'b0, eq || (!a_nan && !b_nan && lt_raw)};
                resp.invalid  = a_nan || b_nan;
                resp.is_float = 1'b0;
            end
            FMIN, FMAX: begin
                resp.invalid = a_snan || b_snan;
                if (a_nan && b_nan) begin
                    resp.data = 32'h7fc00000;
                end else if (a_nan) begin
                    resp.data = b;
                end else if (b_nan) begin
                    resp.data = a;
                end else if (req_q.op == FMIN) begin
                    resp.data = lt_raw ? a : b;
                end else begin
                    resp.data = lt_raw ? b : a;
                end
            end
            // sign injection keeps the magnitude of a
            FSGNJ:   resp.data = {b.sign, a[30:0]};
            FSGNJN:  resp.data = {!b.sign, a[30:0]};
            default: resp.data = {a.sign ^ b.sign, a[30:0]};
        endcase
    end

    fpu_credit_fifo #(
        .payload_t ( fpu_resp_t      ),
        .DEPTH     ( `FPU_LANE_DEPTH )
    ) u_queue (
        .clk_i   ( clk_i        ),
        .rst_n_i ( rst_n_i      ),
        .push_i  ( valid_q      ),
        .data_i  ( resp         ),
        .pop_i   ( pop_i        ),
        .valid_o ( head_valid_o ),
        .data_o  ( head_o       )
    );

endmodule : fpu_lane

// ==== hw/fpu_collect.sv ====
`include "fpu_config.svh"

module fpu_collect import fpu_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic [`FPU_NUM_LANES-1:0] head_valid_i,
    input  fpu_resp_t                 head_i [`FPU_NUM_LANES],
    output logic [`FPU_NUM_LANES-1:0] pop_o,
    input  logic                      resp_credit_i,
    output logic                      resp_valid_o,
    output float32_t                  resp_data_o,
    output logic                      resp_invalid_o,
    output logic                      resp_is_float_o,
    output logic [`FPU_REG_IDX_W-1:0] resp_rd_o,
    output logic                      req_credit_o
);

    localparam int NUM_LANES = `FPU_NUM_LANES;
    localparam int PTR_W     = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam int CRED_W    = `FPU_CRED_W;

    logic [PTR_W-1:0]  drain_ptr;
    logic [CRED_W-1:0] credit_cnt;
    logic              send;
    fpu_resp_t         head_sel;

    // drain in the same round-robin order as the dispatcher
    assign head_sel = head_i[drain_ptr];
    assign send     = head_valid_i[drain_ptr] && (credit_cnt != '0);

    always_comb begin
        pop_o            = '0;
        pop_o[drain_ptr] = send;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            drain_ptr  <= '0;
            credit_cnt <= CRED_W'(`FPU_OUT_CREDITS);
        end else begin
            if (send) begin
                drain_ptr <= (drain_ptr == PTR_W'(NUM_LANES - 1)) ? '0 : drain_ptr + 1'b1;
            end
            credit_cnt <= credit_cnt - CRED_W'(send) + CRED_W'(resp_credit_i);
        end
    end

    // a result leaving frees a queue slot, which goes back to the producer
    assign resp_valid_o    = send;
    assign req_credit_o    = send;
    assign resp_data_o     = head_sel.data;
    assign resp_invalid_o  = head_sel.invalid;
    assign resp_is_float_o = head_sel.is_float;
    assign resp_rd_o       = head_sel.rd;

endmodule : fpu_collect

// ==== hw/fpu_noround_top.sv ====
`include "fpu_config.svh"

module fpu_noround_top import fpu_pkg::*; (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      req_valid_i,
    input  float32_t                  req_a_i,
    input  float32_t                  req_b_i,
    input  fpu_op_t                   req_op_i,
    input  logic [`FPU_REG_IDX_W-1:0] req_rd_i,
    output logic                      req_credit_o,
    output logic                      resp_valid_o,
    output float32_t                  resp_data_o,
    output logic                      resp_invalid_o,
    output logic                      resp_is_float_o,
    output logic [`FPU_REG_IDX_W-1:0] resp_rd_o,
    input  logic                      resp_credit_i
);

    fpu_req_t                  req;
    logic [`FPU_NUM_LANES-1:0] lane_valid;
    logic [`FPU_NUM_LANES-1:0] lane_pop;
    logic [`FPU_NUM_LANES-1:0] lane_head_valid;
    fpu_resp_t                 lane_head [`FPU_NUM_LANES];

    // all lanes see the same request bus
    assign req = '{a: req_a_i, b: req_b_i, op: req_op_i, rd: req_rd_i};

    fpu_dispatch u_dispatch (
        .clk_i        ( clk_i       ),
        .rst_n_i      ( rst_n_i     ),
        .req_valid_i  ( req_valid_i ),
        .lane_valid_o ( lane_valid  )
    );

    // ------------------------------
    // lane array
    // ------------------------------

    for (genvar i = 0; i < `FPU_NUM_LANES; i++) begin : g_lane
        fpu_lane u_lane (
            .clk_i        ( clk_i              ),
            .rst_n_i      ( rst_n_i            ),
            .valid_i      ( lane_valid[i]      ),
            .req_i        ( req                ),
            .pop_i        ( lane_pop[i]        ),
            .head_valid_o ( lane_head_valid[i] ),
            .head_o       ( lane_head[i]       )
        );
    end

    fpu_collect u_collect (
        .clk_i           ( clk_i           ),
        .rst_n_i         ( rst_n_i         ),
        .head_valid_i    ( lane_head_valid ),
        .head_i          ( lane_head       ),
        .pop_o           ( lane_pop        ),
        .resp_credit_i   ( resp_credit_i   ),
        .resp_valid_o    ( resp_valid_o    ),
        .resp_data_o     ( resp_data_o     ),
        .resp_invalid_o  ( resp_invalid_o  ),
        .resp_is_float_o ( resp_is_float_o ),
        .resp_rd_o       ( resp_rd_o       ),
        .req_credit_o    ( req_credit_o    )
    );

endmodule : fpu_noround_top

// ==== verif/fpu_asserts.sv ====
`include "fpu_config.svh"

module fpu_asserts (
    input logic                      clk_i,
    input logic                      rst_n_i,
    input logic                      resp_valid_i,
    input logic [`FPU_CRED_W-1:0]    credit_cnt_i,
    input logic [`FPU_NUM_LANES-1:0] lane_valid_i,
    input logic [`FPU_NUM_LANES-1:0] lane_pop_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // a lane queue is written one edge after its lane takes a request
    logic [`FPU_NUM_LANES-1:0] push_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            push_q <= '0;
        end else begin
            push_q <= lane_valid_i;
        end
    end

    quiet_after_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !resp_valid_i)
        else $error("response valid in the first cycle after reset");

    credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credit_cnt_i <= `FPU_CRED_W'(`FPU_OUT_CREDITS))
        else $error("collector credit counter above its reset value");

    for (genvar i = 0; i < `FPU_NUM_LANES; i++) begin : g_queue
        int occupancy;

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                occupancy <= 0;
            end else begin
                occupancy <= occupancy + int'(push_q[i]) - int'(lane_pop_i[i]);
            end
        end

        no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
            push_q[i] |-> occupancy < `FPU_LANE_DEPTH)
            else $error("lane %0d queue written while full", i);
    end

endmodule : fpu_asserts

bind fpu_noround_top fpu_asserts u_asserts (
    .clk_i        ( clk_i                ),
    .rst_n_i      ( rst_n_i              ),
    .resp_valid_i ( resp_valid_o         ),
    .credit_cnt_i ( u_collect.credit_cnt ),
    .lane_valid_i ( lane_valid           ),
    .lane_pop_i   ( lane_pop             )
);

// ==== verif/fpu_tb.sv ====
`include "fpu_config.svh"

module fpu_tb import fpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // about a thousand requests, the stalled run draining at one result in
    // roughly seven cycles, so the whole run stays far below this
    localparam int MAX_CYCLES  = 20000;
    localparam int NUM_RANDOM  = 300;
    localparam int NUM_STALLED = 200;

    // +0, -0, 1.0, -1.0, +inf, -inf, quiet NaN, signaling NaN
    localparam logic [31:0] SPECIALS [8] = '{
        32'h00000000, 32'h80000000, 32'h3f800000, 32'hbf800000,
        32'h7f800000, 32'hff800000, 32'h7fc00000, 32'h7f800001
    };

    logic                      clk_i = 1'b0;
    logic                      rst_n_i;
    logic                      req_valid_i;
    float32_t                  req_a_i;
    float32_t                  req_b_i;
    fpu_op_t                   req_op_i;
    logic [`FPU_REG_IDX_W-1:0] req_rd_i;
    logic                      req_credit_o;
    logic                      resp_valid_o;
    float32_t                  resp_data_o;
    logic                      resp_invalid_o;
    logic                      resp_is_float_o;
    logic [`FPU_REG_IDX_W-1:0] resp_rd_o;
    logic                      resp_credit_i = 1'b0;

    fpu_resp_t exp_q [$];
    string     test_name = "reset";
    int        cycle_cnt = 0;
    int        spent     = 0;
    int        returned  = 0;
    int        owed      = 0;
    logic      ret_now   = 1'b0;
    logic      slow_mode = 1'b0;
    logic      bp_mode   = 1'b0;
    int        chk_cnt   = 0;
    int        err_cnt   = 0;
    int        drain_err = 0;
    int        tests_run = 0;
    int        chk_base  = 0;
    int        err_base  = 0;

    always #20 clk_i = ~clk_i;

    fpu_noround_top u_fpu_noround_top (.*);

    // ------------------------------
    // expected results
    // ------------------------------

    function automatic fpu_resp_t ref_fpu(input logic [31:0] a, input logic [31:0] b,
                                          input fpu_op_t op, input logic [4:0] rd);
        fpu_resp_t r;
        logic      a_nan;
        logic      b_nan;
        logic      any_snan;
        logic      a_first;
        longint    ka;
        longint    kb;
        a_nan    = (a[30:23] == 8'hff) && (a[22:0] != 23'h0);
        b_nan    = (b[30:23] == 8'hff) && (b[22:0] != 23'h0);
        any_snan = (a_nan && !a[22]) || (b_nan && !b[22]);
        // signed keys, in which both zeros meet at 0
        ka = a[31] ? -longint'(a[30:0]) : longint'(a[30:0]);
        kb = b[31] ? -longint'(b[30:0]) : longint'(b[30:0]);
        // min and max put -0 first when the keys tie
        a_first    = (ka < kb) || (ka == kb && a[31]);
        r          = '0;
        r.rd       = rd;
        r.is_float = (op != FEQ) && (op != FLT) && (op != FLE);
        case (op)
            FEQ: begin
                r.data    = {31'h0, !a_nan && !b_nan && ka == kb};
                r.invalid = any_snan;
            end
            FLT: begin
                r.data    = {31'h0, !a_nan && !b_nan && ka < kb};
                r.invalid = a_nan || b_nan;
            end
            FLE: begin
                r.data    = {31'h0, !a_nan && !b_nan && ka <= kb};
                r.invalid = a_nan || b_nan;
            end
            FMIN, FMAX: begin
                r.invalid = any_snan;
                if (a_nan && b_nan) begin
                    r.data = 32'h7fc00000;
                end else if (a_nan) begin
                    r.data = b;
                end else if (b_nan) begin
                    r.data = a;
                end else begin
                    r.data = ((op == FMIN) == a_first) ? a : b;
                end
            end
            FSGNJ:   r.data = {b[31], a[30:0]};
            FSGNJN:  r.data = {~b[31], a[30:0]};
            default: r.data = {a[31] ^ b[31], a[30:0]};
        endcase
        return r;
    endfunction

    function automatic int producer_credits();
        return `FPU_IN_CREDITS - spent + returned;
    endfunction

    // mostly raw words, with the special values mixed in
    function automatic logic [31:0] rand_operand();
        if ($urandom_range(3, 0) == 0) begin
            return SPECIALS[3'($urandom_range(7, 0))];
        end
        return $urandom();
    endfunction

    // ------------------------------
    // producer
    // ------------------------------

    task automatic issue(input logic [31:0] a, input logic [31:0] b, input fpu_op_t op,
                         input logic [`FPU_REG_IDX_W-1:0] rd);
        while (producer_credits() <= 0) begin
            req_valid_i = 1'b0;
            @(negedge clk_i);
        end
        req_valid_i = 1'b1;
        req_a_i     = a;
        req_b_i     = b;
        req_op_i    = op;
        req_rd_i    = rd;
        spent       = spent + 1;
        exp_q.push_back(ref_fpu(a, b, op, rd));
        @(negedge clk_i);
    endtask

    task automatic start_test(input string name, input logic slow, input logic stall);
        test_name = name;
        slow_mode = slow;
        bp_mode   = stall;
        chk_base  = chk_cnt;
        err_base  = err_cnt + drain_err;
    endtask

    task automatic finish_test();
        req_valid_i = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        // with every result out, every producer credit is back
        if (producer_credits() != `FPU_IN_CREDITS) begin
            $display("error: %s left the producer with %0d credits", test_name,
                     producer_credits());
            drain_err++;
        end
        tests_run++;
        $display("%s finished: %0d checked, %0d errors", test_name, chk_cnt - chk_base,
                 err_cnt + drain_err - err_base);
    endtask

    task automatic run_pairs(input string name, input fpu_op_t first, input fpu_op_t last,
                             input logic slow);
        start_test(name, slow, 1'b0);
        for (int o = int'(first); o <= int'(last); o++) begin
            for (int i = 0; i < 8; i++) begin
                for (int j = 0; j < 8; j++) begin
                    issue(SPECIALS[3'(i)], SPECIALS[3'(j)], fpu_op_t'(3'(o)), 5'(i * 8 + j));
                end
            end
        end
        finish_test();
    endtask

    // ------------------------------
    // consumer and checking
    // ------------------------------

    always @(posedge clk_i) begin : check_resp
        fpu_resp_t got;
        fpu_resp_t want;
        cycle_cnt = cycle_cnt + 1;
        if (rst_n_i) begin
            if (req_credit_o) begin
                returned = returned + 1;
            end
            if (producer_credits() < 0 || producer_credits() > `FPU_IN_CREDITS) begin
                $display("error: producer credit count %0d out of range in %s",
                         producer_credits(), test_name);
                err_cnt++;
            end
            if (resp_valid_o) begin
                got  = {resp_data_o, resp_invalid_o, resp_is_float_o, resp_rd_o};
                owed = owed + 1;
                if (exp_q.size() == 0) begin
                    $display("error: %s produced a response that was never requested",
                             test_name);
                    err_cnt++;
                end else begin
                    want    = exp_q.pop_front();
                    chk_cnt = chk_cnt + 1;
                    if (got !== want) begin
                        $display("Mismatch in %s: expected %h, actual %h", test_name, want, got);
                        err_cnt++;
                    end
                end
            end
            // under back-pressure the consumer sits on its credits for 70 of 100 cycles
            ret_now = (owed > 0) && !(bp_mode && (cycle_cnt % 100) < 70) &&
                      (!slow_mode || $urandom_range(1, 0) == 1);
            if (ret_now) begin
                owed = owed - 1;
            end
        end
    end

    always @(negedge clk_i) begin
        resp_credit_i = ret_now;
    end

    initial begin : watchdog
        wait (cycle_cnt >= MAX_CYCLES);
        $display("error: run did not finish within %0d cycles, %0d results still expected",
                 MAX_CYCLES, exp_q.size());
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        void'($urandom(32'h51ab406a));
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_a_i     = '0;
        req_b_i     = '0;
        req_op_i    = FEQ;
        req_rd_i    = '0;
        repeat (3) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        run_pairs("compare", FEQ, FLE, 1'b0);
        run_pairs("min_max", FMIN, FMAX, 1'b1);
        run_pairs("sign_inject", FSGNJ, FSGNJX, 1'b0);

        start_test("random_mix", 1'b0, 1'b0);
        for (int n = 0; n < NUM_RANDOM; n++) begin
            issue(rand_operand(), rand_operand(), fpu_op_t'(3'($urandom_range(7, 0))),
                  5'($urandom()));
        end
        finish_test();

        start_test("back_pressure", 1'b1, 1'b1);
        for (int n = 0; n < NUM_STALLED; n++) begin
            issue(rand_operand(), rand_operand(), fpu_op_t'(3'($urandom_range(7, 0))),
                  5'($urandom()));
        end
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", tests_run, chk_cnt, err_cnt + drain_err);
        if (err_cnt + drain_err == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : fpu_tb

// ==== project.f ====
+incdir+hw
hw/fpu_pkg.sv
hw/fpu_credit_fifo.sv
hw/fpu_dispatch.sv
hw/fpu_lane.sv
hw/fpu_collect.sv
hw/fpu_noround_top.sv
verif/fpu_asserts.sv
verif/fpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module fpu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/Vfpu_tb > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TEST RESULT: PASS" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
